// File: design/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_t;

  // Load widths in instr[14:12]
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } mem_funct3_t;

  // Stores reuse the signed load codes
  localparam mem_funct3_t sb = lb;
  localparam mem_funct3_t sh = lh;
  localparam mem_funct3_t sw = lw;

  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_op_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    slt  = 3'b010, // Set-less-than forms for op_imm and op_reg
    sltu = 3'b011,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } cmp_op_t;

endpackage

// File: design/pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  typedef enum logic [1:0] {
    pc_plus4   = 2'b00,
    alu_target = 2'b01,
    alu_mod2   = 2'b10
  } pc_sel_t;

  // Operand source chosen by the forwarding unit
  typedef enum logic [1:0] {
    fwd_none   = 2'b00,
    fwd_mem_wb = 2'b01,
    fwd_ex_mem = 2'b10
  } fwd_sel_t;

  // Decoded control word carried down the pipe
  typedef struct packed {
    opcode_t  opcode;
    alu_op_t  aluop;
    cmp_op_t  cmpop;
    pc_sel_t  pc_sel;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     reg_write;
  } ctrl_word_t;

  // EX/MEM pipeline register contents
  typedef struct packed {
    ctrl_word_t ctrl;
    word_t      pc;
    word_t      instr;
    word_t      alu_result;
    word_t      store_data;
    logic       br_en;
    logic [3:0] byte_en;
  } ex_mem_t;

endpackage

// File: design/ex_forward_unit.sv
`timescale 1ns/1ps

module ex_forward_unit (
  input  pipe_pkg::ctrl_word_t id_ex_ctrl,
  input  pipe_pkg::ctrl_word_t ex_mem_ctrl,
  input  pipe_pkg::ctrl_word_t mem_wb_ctrl,
  input  isa_pkg::word_t       alu_in_1,
  input  isa_pkg::word_t       alu_in_2,
  input  isa_pkg::word_t       rs1_val,
  input  isa_pkg::word_t       cmp_in,
  input  isa_pkg::word_t       ex_mem_data,
  input  isa_pkg::word_t       mem_wb_data,
  output isa_pkg::word_t       op_a,
  output isa_pkg::word_t       op_b,
  output isa_pkg::word_t       cmp_a,
  output isa_pkg::word_t       cmp_b
);

  import isa_pkg::*;
  import pipe_pkg::*;

  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;

  // Later stage wins and x0 is never a hazard
  function automatic fwd_sel_t pick_source(reg_idx_t src, logic used,
                                           ctrl_word_t exm, ctrl_word_t mwb);
    if (used && src != '0 && exm.reg_write && exm.rd == src)
      return fwd_ex_mem;
    else if (used && src != '0 && mwb.reg_write && mwb.rd == src)
      return fwd_mem_wb;
    else
      return fwd_none;
  endfunction

  always_comb begin
    fwd_a = pick_source(id_ex_ctrl.rs1, id_ex_ctrl.uses_rs1, ex_mem_ctrl, mem_wb_ctrl);
    fwd_b = pick_source(id_ex_ctrl.rs2, id_ex_ctrl.uses_rs2, ex_mem_ctrl, mem_wb_ctrl);
  end

  always_comb begin
    unique case (fwd_a)
      fwd_ex_mem: begin
        op_a  = ex_mem_data;
        cmp_a = ex_mem_data;
      end
      fwd_mem_wb: begin
        op_a  = mem_wb_data;
        cmp_a = mem_wb_data;
      end
      default: begin
        op_a  = alu_in_1;
        cmp_a = rs1_val;
      end
    endcase
    unique case (fwd_b)
      fwd_ex_mem: begin
        op_b  = ex_mem_data;
        cmp_b = ex_mem_data;
      end
      fwd_mem_wb: begin
        op_b  = mem_wb_data;
        cmp_b = mem_wb_data;
      end
      default: begin
        op_b  = alu_in_2;
        cmp_b = cmp_in;
      end
    endcase
  end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_op_t aluop,
  input  isa_pkg::word_t   a,
  input  isa_pkg::word_t   b,
  output isa_pkg::word_t   result,
  output isa_pkg::word_t   target
);

  import isa_pkg::*;

  word_t    sum;
  logic [4:0] shamt;

  assign sum    = a + b;
  assign shamt  = b[4:0];
  assign target = {sum[31:1], 1'b0}; // JALR and branch target

  always_comb begin
    unique case (aluop)
      alu_add: result = sum;
      alu_sll: result = a << shamt;
      alu_sra: result = word_t'($signed(a) >>> shamt);
      alu_sub: result = a - b;
      alu_xor: result = a ^ b;
      alu_srl: result = a >> shamt;
      alu_or:  result = a | b;
      alu_and: result = a & b;
      default: result = sum;
    endcase
  end

endmodule

// File: design/branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp (
  input  isa_pkg::cmp_op_t cmpop,
  input  isa_pkg::word_t   a,
  input  isa_pkg::word_t   b,
  output logic             br_en
);

  import isa_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  always_comb begin
    unique case (cmpop)
      beq:        br_en = eq;
      bne:        br_en = !eq;
      blt, slt:   br_en = lt_s;
      bge:        br_en = !lt_s;
      bltu, sltu: br_en = lt_u;
      bgeu:       br_en = !lt_u;
      default:    br_en = 1'b0;
    endcase
  end

endmodule

// File: design/ex_mem_latch.sv
`timescale 1ns/1ps

module ex_mem_latch (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ma_stall,
  input  pipe_pkg::ctrl_word_t id_ex_ctrl,
  input  isa_pkg::word_t       pc,
  input  isa_pkg::word_t       instr,
  input  isa_pkg::word_t       alu_result,
  input  isa_pkg::word_t       rs2_val,
  input  logic                 br_en,
  output pipe_pkg::pc_sel_t    pc_sel,
  output logic                 br_taken,
  output pipe_pkg::ex_mem_t    ex_mem
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [1:0] offset;
  logic [3:0] byte_en;
  logic       is_mem;
  ex_mem_t    ex_mem_next;

  assign offset = alu_result[1:0];
  assign is_mem = (id_ex_ctrl.opcode == op_load) || (id_ex_ctrl.opcode == op_store);

  // Redirect on taken branch or any jump
  always_comb begin
    br_taken = (br_en && id_ex_ctrl.opcode == op_br) ||
               id_ex_ctrl.opcode == op_jal || id_ex_ctrl.opcode == op_jalr;
    pc_sel   = br_taken ? id_ex_ctrl.pc_sel : pc_plus4;
  end

  // Shifted masks drop bits above byte 3
  always_comb begin
    byte_en = 4'b0000;
    if (is_mem) begin
      unique case (mem_funct3_t'(instr[14:12]))
        lb, lbu: byte_en = 4'b0001 << offset;
        lh, lhu: byte_en = 4'b0011 << offset;
        lw:      byte_en = 4'b1111 << offset;
        default: byte_en = 4'b1111;
      endcase
    end
  end

  always_comb begin
    ex_mem_next.ctrl       = id_ex_ctrl;
    ex_mem_next.pc         = pc;
    ex_mem_next.instr      = instr;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.store_data = rs2_val;
    ex_mem_next.br_en      = br_en;
    ex_mem_next.byte_en    = byte_en;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0; // Bubble
    end else if (!ma_stall) begin
      ex_mem <= ex_mem_next;
    end
  end

endmodule

// File: design/instruction_execute.sv
`timescale 1ns/1ps

module instruction_execute (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::ctrl_word_t id_ex_ctrl,
  input  isa_pkg::word_t       pc,
  input  isa_pkg::word_t       instr,
  input  isa_pkg::word_t       alu_in_1,
  input  isa_pkg::word_t       alu_in_2,
  input  isa_pkg::word_t       rs1_val,
  input  isa_pkg::word_t       cmp_in,
  input  isa_pkg::word_t       rs2_val,
  input  logic                 ma_stall,
  input  pipe_pkg::ctrl_word_t mem_wb_ctrl,
  input  isa_pkg::word_t       mem_wb_data,
  output pipe_pkg::ex_mem_t    ex_mem,
  output pipe_pkg::pc_sel_t    pc_sel,
  output logic                 br_taken,
  output isa_pkg::word_t       alu_target
);

  import isa_pkg::*;
  import pipe_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      cmp_a;
  word_t      cmp_b;
  word_t      alu_result;
  logic       br_en;
  ctrl_word_t ex_mem_ctrl;
  word_t      ex_mem_data;

  // EX/MEM feedback for forwarding
  assign ex_mem_ctrl = ex_mem.ctrl;
  assign ex_mem_data = ex_mem.alu_result;

  ex_forward_unit fwd0 (
    .id_ex_ctrl  (id_ex_ctrl),
    .ex_mem_ctrl (ex_mem_ctrl),
    .mem_wb_ctrl (mem_wb_ctrl),
    .alu_in_1    (alu_in_1),
    .alu_in_2    (alu_in_2),
    .rs1_val     (rs1_val),
    .cmp_in      (cmp_in),
    .ex_mem_data (ex_mem_data),
    .mem_wb_data (mem_wb_data),
    .op_a        (op_a),
    .op_b        (op_b),
    .cmp_a       (cmp_a),
    .cmp_b       (cmp_b)
  );

  alu alu0 (
    .aluop  (id_ex_ctrl.aluop),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result),
    .target (alu_target)
  );

  branch_cmp cmp0 (
    .cmpop (id_ex_ctrl.cmpop),
    .a     (cmp_a),
    .b     (cmp_b),
    .br_en (br_en)
  );

  ex_mem_latch latch0 (
    .clk        (clk),
    .rst        (rst),
    .ma_stall   (ma_stall),
    .id_ex_ctrl (id_ex_ctrl),
    .pc         (pc),
    .instr      (instr),
    .alu_result (alu_result),
    .rs2_val    (rs2_val),
    .br_en      (br_en),
    .pc_sel     (pc_sel),
    .br_taken   (br_taken),
    .ex_mem     (ex_mem)
  );

endmodule

// File: bench/execute_asserts.sv
`timescale 1ns/1ps

module execute_asserts (
  input logic              clk,
  input logic              rst,
  input logic              ma_stall,
  input logic              br_taken,
  input pipe_pkg::pc_sel_t pc_sel,
  input pipe_pkg::ex_mem_t ex_mem
);

  import isa_pkg::*;
  import pipe_pkg::*;

  int failures = 0;

  byte_en_mem_only: assert property (@(posedge clk) disable iff (rst)
    !(ex_mem.ctrl.opcode inside {op_load, op_store}) |-> ex_mem.byte_en == 4'b0000)
    else begin
      $error("byte_en is set for an opcode that is neither load nor store");
      failures++;
    end

  // Register frozen for the whole stall cycle
  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    ma_stall |=> $stable(ex_mem))
    else begin
      $error("ex_mem changed while ma_stall was high");
      failures++;
    end

  no_redirect_plus4: assert property (@(posedge clk) disable iff (rst)
    !br_taken |-> pc_sel == pc_plus4)
    else begin
      $error("pc_sel is not pc_plus4 while br_taken is low");
      failures++;
    end

endmodule

bind ex_mem_latch execute_asserts asserts0 (
  .clk      (clk),
  .rst      (rst),
  .ma_stall (ma_stall),
  .br_taken (br_taken),
  .pc_sel   (pc_sel),
  .ex_mem   (ex_mem)
);

// File: bench/tb_execute.sv
`timescale 1ns/1ps

module tb_execute;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int steps        = 200;
  localparam int total_cycles = 5 * steps + 6;

  logic       clk;
  logic       rst;
  logic       ma_stall;
  ctrl_word_t id_ex_ctrl;
  ctrl_word_t mem_wb_ctrl;
  word_t      pc;
  word_t      instr;
  word_t      alu_in_1;
  word_t      alu_in_2;
  word_t      rs1_val;
  word_t      cmp_in;
  word_t      rs2_val;
  word_t      mem_wb_data;
  ex_mem_t    ex_mem;
  pc_sel_t    pc_sel;
  logic       br_taken;
  word_t      alu_target;

  integer  seed        = 57672;
  int      errors      = 0;
  int      checks      = 0;
  int      test_errors = 0;
  ex_mem_t exp_q;    // Model EX/MEM register
  ex_mem_t exp_next;

  instruction_execute dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(total_cycles * 20 + 1000);
    $display("Watchdog expired: the run did not end within %0d cycles", total_cycles);
    $display("Test failed");
    $finish;
  end

  task automatic compare(string what, logic [191:0] got, logic [191:0] want);
    checks++;
    assert (got === want) else begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, want);
      errors++;
      test_errors++;
    end
  endtask

  // Later stage first and x0 never forwarded
  function automatic word_t operand(reg_idx_t src, logic used, word_t plain);
    if (used && src != '0 && exp_q.ctrl.reg_write && exp_q.ctrl.rd == src)
      return exp_q.alu_result;
    if (used && src != '0 && mem_wb_ctrl.reg_write && mem_wb_ctrl.rd == src)
      return mem_wb_data;
    return plain;
  endfunction

  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
      alu_xor: return a ^ b;
      alu_or:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic cmp_model(cmp_op_t op, word_t a, word_t b);
    word_t ba;
    word_t bb;
    ba = a ^ 32'h8000_0000; // Biased so unsigned order is signed order
    bb = b ^ 32'h8000_0000;
    case (op)
      beq:        return a == b;
      bne:        return a != b;
      blt, slt:   return ba < bb;
      bge:        return ba >= bb;
      bltu, sltu: return a < b;
      default:    return a >= b;
    endcase
  endfunction

  function automatic logic [3:0] byte_en_model(opcode_t op, logic [2:0] f3, logic [1:0] off);
    logic [7:0] span;
    if (op != op_load && op != op_store)
      return 4'b0000;
    case (mem_funct3_t'(f3))
      lb, lbu: span = 8'b0000_0001;
      lh, lhu: span = 8'b0000_0011;
      lw:      span = 8'b0000_1111;
      default: return 4'b1111;
    endcase
    span = span << off;
    return span[3:0]; // Lanes past byte 3 fall off
  endfunction

  function automatic opcode_t pick_opcode(int k);
    case (k)
      0: return op_lui;
      1: return op_auipc;
      2: return op_jal;
      3: return op_jalr;
      4: return op_br;
      5: return op_load;
      6: return op_store;
      7: return op_imm;
      default: return op_reg;
    endcase
  endfunction

  task automatic drive_inputs(int mode);
    ctrl_word_t c;
    c.opcode = pick_opcode($unsigned($random(seed)) % 9);
    if (mode == 3)
      c.opcode = pick_opcode(2 + $unsigned($random(seed)) % 3); // jal, jalr or br
    if (mode == 5)
      c.opcode = ($random(seed) & 1) ? op_load : op_store;
    c.aluop     = alu_op_t'(3'($random(seed)));
    c.cmpop     = cmp_op_t'(3'($random(seed)));
    c.pc_sel    = ($random(seed) & 1) ? alu_mod2 : pipe_pkg::alu_target;
    c.rs1       = reg_idx_t'($random(seed) & 3); // Small indices for frequent hazards
    c.rs2       = reg_idx_t'($random(seed) & 3);
    c.rd        = reg_idx_t'($random(seed) & 3);
    c.uses_rs1  = (mode == 4 || mode == 6) ? 1'($random(seed)) : 1'b0;
    c.uses_rs2  = (mode == 4 || mode == 6) ? 1'($random(seed)) : 1'b0;
    c.reg_write = 1'($random(seed));
    id_ex_ctrl  = c;
    mem_wb_ctrl = '0;
    mem_wb_ctrl.rd        = reg_idx_t'($random(seed) & 3);
    mem_wb_ctrl.reg_write = 1'($random(seed));
    mem_wb_data = $random(seed);
    pc          = $random(seed);
    instr       = $random(seed);
    alu_in_1    = $random(seed);
    alu_in_2    = $random(seed);
    rs1_val     = $random(seed);
    rs2_val     = $random(seed);
    cmp_in      = (($random(seed) & 3) == 0) ? rs1_val : $random(seed);
    ma_stall    = (mode == 6) ? 1'($random(seed)) : 1'b0;
  endtask

  task automatic step(int mode);
    word_t a;
    word_t b;
    word_t res;
    word_t tgt;
    logic  br;
    logic  taken;
    @(posedge clk);
    #2;
    exp_q = exp_next;
    compare("ex_mem", 192'(ex_mem), 192'(exp_q));
    drive_inputs(mode);
    #5;
    a     = operand(id_ex_ctrl.rs1, id_ex_ctrl.uses_rs1, alu_in_1);
    b     = operand(id_ex_ctrl.rs2, id_ex_ctrl.uses_rs2, alu_in_2);
    res   = alu_model(id_ex_ctrl.aluop, a, b);
    tgt   = (a + b) & 32'hffff_fffe;
    br    = cmp_model(id_ex_ctrl.cmpop,
                      operand(id_ex_ctrl.rs1, id_ex_ctrl.uses_rs1, rs1_val),
                      operand(id_ex_ctrl.rs2, id_ex_ctrl.uses_rs2, cmp_in));
    taken = (br && id_ex_ctrl.opcode == op_br) || id_ex_ctrl.opcode inside {op_jal, op_jalr};
    compare("alu_target", 192'(alu_target), 192'(tgt));
    compare("br_taken", 192'(br_taken), 192'(taken));
    compare("pc_sel", 192'(pc_sel), 192'(taken ? id_ex_ctrl.pc_sel : pc_plus4));
    if (!ma_stall) begin
      exp_next = '{ctrl: id_ex_ctrl, pc: pc, instr: instr, alu_result: res,
                   store_data: rs2_val, br_en: br,
                   byte_en: byte_en_model(id_ex_ctrl.opcode, instr[14:12], res[1:0])};
    end
  endtask

  task automatic report(int num, string name);
    if (test_errors == 0)
      $display("test %0d %s: pass", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, test_errors);
  endtask

  task automatic run_test(int num, string name);
    test_errors = 0;
    repeat (steps) step(num);
    if (num == 6) begin
      @(posedge clk); // Last loaded value
      #2;
      compare("ex_mem", 192'(ex_mem), 192'(exp_next));
    end
    report(num, name);
  endtask

  initial begin
    rst         = 1'b1;
    ma_stall    = 1'b1;
    id_ex_ctrl  = '0;
    mem_wb_ctrl = '0;
    mem_wb_data = '0;
    pc          = '0;
    instr       = '0;
    alu_in_1    = '0;
    alu_in_2    = '0;
    rs1_val     = '0;
    cmp_in      = '0;
    rs2_val     = '0;
    exp_next    = '0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    compare("ex_mem after reset", 192'(ex_mem), 192'(0));
    report(1, "reset");
    run_test(2, "alu");
    run_test(3, "redirect");
    run_test(4, "forwarding");
    run_test(5, "byte enables");
    run_test(6, "stall");
    errors += dut0.latch0.asserts0.failures;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/ex_forward_unit.sv
design/alu.sv
design/branch_cmp.sv
design/ex_mem_latch.sv
design/instruction_execute.sv
bench/execute_asserts.sv
bench/tb_execute.sv

// File: Makefile
TOP = tb_execute

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
